/* sources.f */
+incdir+.
dmem_pkg.sv
io_bram.sv
main_mem.sv
dcache_direct.sv
dmem_cache_bridge.sv
dmem_subsys_top.sv
tb_dmem_subsys.sv

/* Bender.yml */
package:
  name: dmem_subsys

sources:
  - include_dirs:
      - .
    files:
      - dmem_pkg.sv
      - io_bram.sv
      - main_mem.sv
      - dcache_direct.sv
      - dmem_cache_bridge.sv
      - dmem_subsys_top.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_dmem_subsys.sv

/* tb_dmem_subsys.sv */
`default_nettype none

`include "dmem_cfg.svh"

module tb_dmem_subsys;

  localparam int MEM_IDX_W = $clog2(`DMEM_MEM_WORDS);
  localparam int IO_IDX_W  = $clog2(`DMEM_IO_WORDS);
  // Flipping this bit keeps the cache index and changes the tag
  localparam int CONFLICT_BIT = 2 + dmem_pkg::DCACHE_IDX_W;

  // Access counts per test, used for the watchdog budget
  localparam int N_RW        = 8;
  localparam int N_ACCESSES  = 4 * N_RW + 4 * 5 + 3 * 4 + 4 * 4 + 8 * 4;
  localparam int TIMEOUT_CYCLES = N_ACCESSES * (2 * `DMEM_MEM_LATENCY + 8) + 200;

  logic                 clk;
  logic                 rst_n;
  logic                 dmem_ren;
  dmem_pkg::dmem_addr_t dmem_raddr;
  dmem_pkg::dmem_data_t dmem_rdata;
  logic                 dmem_we;
  dmem_pkg::dmem_addr_t dmem_waddr;
  dmem_pkg::dmem_data_t dmem_wdata;
  dmem_pkg::dmem_strb_t dmem_wstrb;
  logic                 dmem_stall;

  // Reference copies of main memory and the I/O BRAM
  dmem_pkg::dmem_data_t ref_mem [`DMEM_MEM_WORDS];
  dmem_pkg::dmem_data_t ref_io  [`DMEM_IO_WORDS];

  logic [31:0] lcg_state;
  int          error_count;
  int          tests_passed;
  int          tests_failed;
  int          cycle_count;

  dmem_subsys_top i_dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .dmem_ren   (dmem_ren),
    .dmem_raddr (dmem_raddr),
    .dmem_rdata (dmem_rdata),
    .dmem_we    (dmem_we),
    .dmem_waddr (dmem_waddr),
    .dmem_wdata (dmem_wdata),
    .dmem_wstrb (dmem_wstrb),
    .dmem_stall (dmem_stall)
  );

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
  end

  // Watchdog
  initial begin
    wait (cycle_count >= TIMEOUT_CYCLES);
    $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("Some tests failed");
    $finish;
  end

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Word-aligned address inside main memory, upper LCG bits only
  function automatic dmem_pkg::dmem_addr_t rand_cached_addr();
    logic [31:0] r;
    r = next_rand();
    return dmem_pkg::dmem_addr_t'(r[31:16] % `DMEM_MEM_WORDS) << 2;
  endfunction

  // I/O address with spare upper bits to exercise the BRAM wrap
  function automatic dmem_pkg::dmem_addr_t rand_io_addr();
    logic [31:0] r;
    r = next_rand();
    return 32'h8000_0000 | (32'(r[29:18]) << 2);
  endfunction

  // Byte lanes under the strobe take the new data
  function automatic dmem_pkg::dmem_data_t merge_bytes(input dmem_pkg::dmem_data_t old_word,
                                                       input dmem_pkg::dmem_data_t new_word,
                                                       input dmem_pkg::dmem_strb_t strb);
    dmem_pkg::dmem_data_t res;
    res = old_word;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        res[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return res;
  endfunction

  function automatic dmem_pkg::dmem_data_t ref_read(input dmem_pkg::dmem_addr_t addr);
    if (addr[31]) begin
      return ref_io[addr[2 +: IO_IDX_W]];
    end
    return ref_mem[addr[2 +: MEM_IDX_W]];
  endfunction

  task automatic check_word(input string name, input dmem_pkg::dmem_addr_t addr,
                            input dmem_pkg::dmem_data_t exp, input dmem_pkg::dmem_data_t got);
    assert (got === exp) else begin
      $display("[FAIL] t=%0t %s at %08h expected %08h got %08h", $time, name, addr, exp, got);
      error_count++;
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic got);
    assert (got === exp) else begin
      $display("[FAIL] t=%0t %s expected %b got %b", $time, name, exp, got);
      error_count++;
    end
  endtask

  // Returns at the falling edge of the first unstalled cycle
  task automatic wait_response(output int stalls);
    stalls = 0;
    @(negedge clk);
    while (dmem_stall) begin
      stalls++;
      @(negedge clk);
    end
  endtask

  // One cooldown cycle, then an idle cycle that lets the held word go
  task automatic wait_cooldown();
    @(negedge clk);
    check_bit("dmem_stall (cooldown)", 1'b1, dmem_stall);
    @(negedge clk);
    check_bit("dmem_stall (after cooldown)", 1'b0, dmem_stall);
  endtask

  task automatic cpu_write(input dmem_pkg::dmem_addr_t addr, input dmem_pkg::dmem_data_t data,
                           input dmem_pkg::dmem_strb_t strb);
    int stalls;
    @(posedge clk);
    #1;
    dmem_we    = 1'b1;
    dmem_waddr = addr;
    dmem_wdata = data;
    dmem_wstrb = strb;
    if (addr[31]) begin
      // I/O write lands at the request edge with no stall
      @(negedge clk);
      check_bit("dmem_stall (I/O write)", 1'b0, dmem_stall);
      ref_io[addr[2 +: IO_IDX_W]] = merge_bytes(ref_io[addr[2 +: IO_IDX_W]], data, strb);
    end else begin
      wait_response(stalls);
      ref_mem[addr[2 +: MEM_IDX_W]] = merge_bytes(ref_mem[addr[2 +: MEM_IDX_W]], data, strb);
    end
    @(posedge clk);
    #1;
    dmem_we = 1'b0;
    if (!addr[31]) begin
      wait_cooldown();
    end
  endtask

  task automatic cpu_read(input dmem_pkg::dmem_addr_t addr, output dmem_pkg::dmem_data_t data,
                          output int stalls);
    @(posedge clk);
    #1;
    dmem_ren   = 1'b1;
    dmem_raddr = addr;
    stalls     = 0;
    if (addr[31]) begin
      @(negedge clk);
      check_bit("dmem_stall (I/O read)", 1'b0, dmem_stall);
      @(posedge clk);
      #1;
      dmem_ren = 1'b0;
      // BRAM data shows up the cycle after the request
      @(negedge clk);
      data = dmem_rdata;
      check_bit("dmem_stall (I/O read data)", 1'b0, dmem_stall);
    end else begin
      wait_response(stalls);
      data = dmem_rdata;
      @(posedge clk);
      #1;
      dmem_ren = 1'b0;
      // Loaded word stays on the port through the cooldown cycle
      @(negedge clk);
      check_bit("dmem_stall (cooldown)", 1'b1, dmem_stall);
      check_word("dmem_rdata (held)", addr, ref_read(addr), dmem_rdata);
      @(negedge clk);
      check_bit("dmem_stall (after cooldown)", 1'b0, dmem_stall);
    end
  endtask

  task automatic check_read(input dmem_pkg::dmem_addr_t addr);
    dmem_pkg::dmem_data_t got;
    int                   stalls;
    cpu_read(addr, got, stalls);
    check_word("dmem_rdata", addr, ref_read(addr), got);
  endtask

  task automatic finish_test(input string name, input int errors_before);
    if (error_count == errors_before) begin
      tests_passed++;
      $display("Test %s: ok", name);
    end else begin
      tests_failed++;
      $display("Test %s: %0d errors", name, error_count - errors_before);
    end
  endtask

  task automatic test_reset();
    int errs;
    errs = error_count;
    repeat (5) begin
      @(negedge clk);
      check_bit("dmem_stall (idle after reset)", 1'b0, dmem_stall);
    end
    finish_test("reset", errs);
  endtask

  // Write miss, fill on read, write hit, hit read
  task automatic test_write_read();
    int                   errs;
    dmem_pkg::dmem_addr_t a;
    errs = error_count;
    for (int i = 0; i < N_RW; i++) begin
      a = rand_cached_addr();
      cpu_write(a, next_rand(), 4'hf);
      check_read(a);
      cpu_write(a, next_rand(), 4'hf);
      check_read(a);
    end
    finish_test("cached write/read", errs);
  endtask

  task automatic test_byte_strobes();
    int                   errs;
    dmem_pkg::dmem_addr_t a;
    dmem_pkg::dmem_strb_t first [4];
    errs  = error_count;
    first = '{4'b0011, 4'b0101, 4'b0001, 4'b1000};
    for (int i = 0; i < 4; i++) begin
      a = rand_cached_addr();
      // Evict the line so the first partial write misses
      check_read(a ^ (32'd1 << CONFLICT_BIT));
      cpu_write(a, next_rand(), first[i]);
      check_read(a);
      cpu_write(a, next_rand(), ~first[i]);
      check_read(a);
    end
    finish_test("byte strobes", errs);
  endtask

  task automatic test_hit_miss();
    int                   errs;
    int                   miss_stalls;
    int                   hit_stalls;
    dmem_pkg::dmem_addr_t a;
    dmem_pkg::dmem_data_t got;
    errs = error_count;
    for (int i = 0; i < 3; i++) begin
      a = rand_cached_addr();
      check_read(a);
      check_read(a ^ (32'd1 << CONFLICT_BIT));
      cpu_read(a, got, miss_stalls);
      check_word("dmem_rdata (miss)", a, ref_read(a), got);
      cpu_read(a, got, hit_stalls);
      check_word("dmem_rdata (hit)", a, ref_read(a), got);
      assert (miss_stalls > hit_stalls) else begin
        $display("Read at %08h after eviction stalled %0d cycles, the repeat read %0d",
                 a, miss_stalls, hit_stalls);
        error_count++;
      end
    end
    finish_test("hit versus miss", errs);
  endtask

  // Same low bits in both regions, each keeps its own data
  task automatic test_io_bypass();
    int                   errs;
    dmem_pkg::dmem_addr_t c;
    dmem_pkg::dmem_addr_t io;
    errs = error_count;
    for (int i = 0; i < 4; i++) begin
      c  = rand_cached_addr();
      io = c | 32'h8000_0000;
      cpu_write(c, next_rand(), 4'hf);
      cpu_write(io, next_rand(), dmem_pkg::dmem_strb_t'(next_rand() >> 20));
      check_read(io);
      check_read(c);
    end
    finish_test("I/O bypass", errs);
  endtask

  task automatic test_interleave();
    int                   errs;
    dmem_pkg::dmem_addr_t c;
    dmem_pkg::dmem_addr_t io;
    errs = error_count;
    for (int i = 0; i < 8; i++) begin
      io = rand_io_addr();
      c  = rand_cached_addr();
      cpu_write(io, next_rand(), dmem_pkg::dmem_strb_t'(next_rand() >> 20));
      cpu_write(c, next_rand(), dmem_pkg::dmem_strb_t'(next_rand() >> 20));
      check_read(io);
      check_read(c);
    end
    finish_test("interleaving", errs);
  endtask

  initial begin
    clk          = 1'b0;
    rst_n        = 1'b0;
    dmem_ren     = 1'b0;
    dmem_raddr   = '0;
    dmem_we      = 1'b0;
    dmem_waddr   = '0;
    dmem_wdata   = '0;
    dmem_wstrb   = '0;
    lcg_state    = 32'ha51056f8;
    error_count  = 0;
    tests_passed = 0;
    tests_failed = 0;
    cycle_count  = 0;
    // Both memories are cleared at time zero
    for (int i = 0; i < `DMEM_MEM_WORDS; i++) begin
      ref_mem[i] = '0;
    end
    for (int i = 0; i < `DMEM_IO_WORDS; i++) begin
      ref_io[i] = '0;
    end

    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;

    test_reset();
    test_write_read();
    test_byte_strobes();
    test_hit_miss();
    test_io_bypass();
    test_interleave();

    $display("Tests: %0d passed, %0d failed, %0d check errors",
             tests_passed, tests_failed, error_count);
    if (error_count == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* dmem_subsys_top.sv */
`default_nettype none

module dmem_subsys_top (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 dmem_ren,
  input  dmem_pkg::dmem_addr_t dmem_raddr,
  output dmem_pkg::dmem_data_t dmem_rdata,
  input  logic                 dmem_we,
  input  dmem_pkg::dmem_addr_t dmem_waddr,
  input  dmem_pkg::dmem_data_t dmem_wdata,
  input  dmem_pkg::dmem_strb_t dmem_wstrb,
  output logic                 dmem_stall
);

  // Bridge to cache
  logic                 cache_rd_valid;
  dmem_pkg::dmem_addr_t cache_rd_addr;
  dmem_pkg::dmem_data_t cache_rd_data;
  logic                 cache_rd_data_valid;
  logic                 cache_wr_valid;
  dmem_pkg::dmem_addr_t cache_wr_addr;
  dmem_pkg::dmem_data_t cache_wr_data;
  dmem_pkg::dmem_strb_t cache_wr_strb;
  logic                 cache_wr_ready;

  // Cache to main memory
  logic                 mem_req;
  logic                 mem_we;
  dmem_pkg::dmem_addr_t mem_addr;
  dmem_pkg::dmem_data_t mem_wdata;
  dmem_pkg::dmem_strb_t mem_wstrb;
  logic                 mem_ack;
  dmem_pkg::dmem_data_t mem_rdata;

  // Bridge to I/O BRAM
  logic                 io_ren;
  dmem_pkg::dmem_addr_t io_raddr;
  dmem_pkg::dmem_data_t io_rdata;
  logic                 io_wen;
  dmem_pkg::dmem_addr_t io_waddr;
  dmem_pkg::dmem_data_t io_wdata;
  dmem_pkg::dmem_strb_t io_wstrb;

  dmem_cache_bridge i_bridge (
    .clk                 (clk),
    .rst_n               (rst_n),
    .dmem_ren            (dmem_ren),
    .dmem_raddr          (dmem_raddr),
    .dmem_rdata          (dmem_rdata),
    .dmem_we             (dmem_we),
    .dmem_waddr          (dmem_waddr),
    .dmem_wdata          (dmem_wdata),
    .dmem_wstrb          (dmem_wstrb),
    .dmem_stall          (dmem_stall),
    .cache_rd_valid      (cache_rd_valid),
    .cache_rd_addr       (cache_rd_addr),
    .cache_rd_data       (cache_rd_data),
    .cache_rd_data_valid (cache_rd_data_valid),
    .cache_wr_valid      (cache_wr_valid),
    .cache_wr_addr       (cache_wr_addr),
    .cache_wr_data       (cache_wr_data),
    .cache_wr_strb       (cache_wr_strb),
    .cache_wr_ready      (cache_wr_ready),
    .io_ren              (io_ren),
    .io_raddr            (io_raddr),
    .io_rdata            (io_rdata),
    .io_wen              (io_wen),
    .io_waddr            (io_waddr),
    .io_wdata            (io_wdata),
    .io_wstrb            (io_wstrb)
  );

  dcache_direct i_cache (
    .clk                 (clk),
    .rst_n               (rst_n),
    .cache_rd_valid      (cache_rd_valid),
    .cache_rd_addr       (cache_rd_addr),
    .cache_rd_data       (cache_rd_data),
    .cache_rd_data_valid (cache_rd_data_valid),
    .cache_wr_valid      (cache_wr_valid),
    .cache_wr_addr       (cache_wr_addr),
    .cache_wr_data       (cache_wr_data),
    .cache_wr_strb       (cache_wr_strb),
    .cache_wr_ready      (cache_wr_ready),
    .mem_req             (mem_req),
    .mem_we              (mem_we),
    .mem_addr            (mem_addr),
    .mem_wdata           (mem_wdata),
    .mem_wstrb           (mem_wstrb),
    .mem_ack             (mem_ack),
    .mem_rdata           (mem_rdata)
  );

  main_mem i_main_mem (
    .clk       (clk),
    .rst_n     (rst_n),
    .mem_req   (mem_req),
    .mem_we    (mem_we),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_wstrb (mem_wstrb),
    .mem_ack   (mem_ack),
    .mem_rdata (mem_rdata)
  );

  io_bram i_io_bram (
    .clk      (clk),
    .io_ren   (io_ren),
    .io_raddr (io_raddr),
    .io_wen   (io_wen),
    .io_waddr (io_waddr),
    .io_wdata (io_wdata),
    .io_wstrb (io_wstrb),
    .io_rdata (io_rdata)
  );

endmodule

`default_nettype wire

/* dmem_cache_bridge.sv */
`default_nettype none

module dmem_cache_bridge (
  input  logic                 clk,
  input  logic                 rst_n,

  // CPU data port, pulse and level driven
  input  logic                 dmem_ren,
  input  dmem_pkg::dmem_addr_t dmem_raddr,
  output dmem_pkg::dmem_data_t dmem_rdata,
  input  logic                 dmem_we,
  input  dmem_pkg::dmem_addr_t dmem_waddr,
  input  dmem_pkg::dmem_data_t dmem_wdata,
  input  dmem_pkg::dmem_strb_t dmem_wstrb,
  output logic                 dmem_stall,

  // Cache read channel
  output logic                 cache_rd_valid,
  output dmem_pkg::dmem_addr_t cache_rd_addr,
  input  dmem_pkg::dmem_data_t cache_rd_data,
  input  logic                 cache_rd_data_valid,

  // Cache write channel
  output logic                 cache_wr_valid,
  output dmem_pkg::dmem_addr_t cache_wr_addr,
  output dmem_pkg::dmem_data_t cache_wr_data,
  output dmem_pkg::dmem_strb_t cache_wr_strb,
  input  logic                 cache_wr_ready,

  // I/O BRAM port
  output logic                 io_ren,
  output dmem_pkg::dmem_addr_t io_raddr,
  input  dmem_pkg::dmem_data_t io_rdata,
  output logic                 io_wen,
  output dmem_pkg::dmem_addr_t io_waddr,
  output dmem_pkg::dmem_data_t io_wdata,
  output dmem_pkg::dmem_strb_t io_wstrb
);

  typedef enum logic [1:0] {
    BR_IDLE,
    BR_READ,
    BR_WRITE
  } bridge_state_t;

  bridge_state_t state;
  bridge_state_t state_next;

  // Region decode on the raw CPU addresses
  logic rd_is_io;
  logic wr_is_io;
  // New requests only accepted in idle outside cooldown
  logic accept;
  // Cooldown flag, set for the cycle after a cache completion
  logic completing;
  // Last accepted read went to the I/O BRAM
  logic io_sel_q;

  // Captured request payload for the cache
  dmem_pkg::dmem_addr_t rd_addr_q;
  dmem_pkg::dmem_addr_t wr_addr_q;
  dmem_pkg::dmem_data_t wr_data_q;
  dmem_pkg::dmem_strb_t wr_strb_q;

  // Loaded word held until the pipeline moves on
  dmem_pkg::dmem_data_t held_data_q;
  logic                 held_valid_q;

  assign rd_is_io = dmem_raddr[31];
  assign wr_is_io = dmem_waddr[31];
  assign accept   = (state == BR_IDLE) && !completing;

  always_comb begin
    state_next = state;
    case (state)
      BR_IDLE: begin
        if (accept) begin
          // Reads take priority, the CPU never issues both anyway
          if (dmem_ren && !rd_is_io) begin
            state_next = BR_READ;
          end else if (dmem_we && !wr_is_io) begin
            state_next = BR_WRITE;
          end
        end
      end
      BR_READ: begin
        // Return to idle so stall can drop in the response cycle
        if (cache_rd_data_valid) begin
          state_next = BR_IDLE;
        end
      end
      BR_WRITE: begin
        if (cache_wr_ready) begin
          state_next = BR_IDLE;
        end
      end
      default: begin
        state_next = BR_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state      <= BR_IDLE;
      completing <= 1'b0;
      io_sel_q   <= 1'b0;
    end else begin
      state      <= state_next;
      completing <= ((state == BR_READ) && cache_rd_data_valid) ||
                    ((state == BR_WRITE) && cache_wr_ready);
      // Remember the read source for the data mux one cycle later
      if (accept && dmem_ren) begin
        io_sel_q <= rd_is_io;
      end
    end
  end

  // Payload captured on entry to read or write
  always_ff @(posedge clk) begin
    if ((state == BR_IDLE) && (state_next == BR_READ)) begin
      rd_addr_q <= dmem_raddr;
    end
    if ((state == BR_IDLE) && (state_next == BR_WRITE)) begin
      wr_addr_q <= dmem_waddr;
      wr_data_q <= dmem_wdata;
      wr_strb_q <= dmem_wstrb;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      held_valid_q <= 1'b0;
    end else begin
      // Release once the CPU has seen an unstalled cycle
      if (held_valid_q && !dmem_stall) begin
        held_valid_q <= 1'b0;
      end
      // A fresh response wins over the release
      if ((state == BR_READ) && cache_rd_data_valid) begin
        held_valid_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if ((state == BR_READ) && cache_rd_data_valid) begin
      held_data_q <= cache_rd_data;
    end
  end

  // Valid drops in the response cycle so no second read is started
  assign cache_rd_valid = (state == BR_READ) && !cache_rd_data_valid;
  assign cache_rd_addr  = rd_addr_q;

  // Write valid stays up through the ready cycle for the handshake
  assign cache_wr_valid = (state == BR_WRITE);
  assign cache_wr_addr  = wr_addr_q;
  assign cache_wr_data  = wr_data_q;
  assign cache_wr_strb  = wr_strb_q;

  // I/O bypass, enables gated so a held request is not repeated
  assign io_ren   = accept && dmem_ren && rd_is_io;
  assign io_raddr = dmem_raddr;
  assign io_wen   = accept && dmem_we && wr_is_io;
  assign io_waddr = dmem_waddr;
  assign io_wdata = dmem_wdata;
  assign io_wstrb = dmem_wstrb;

  // Live cache data in the response cycle, held copy afterwards
  assign dmem_rdata = io_sel_q ? io_rdata :
                      ((held_valid_q && !cache_rd_data_valid) ? held_data_q : cache_rd_data);

  // Stall from next state so it rises with the request, plus cooldown
  assign dmem_stall = (state_next != BR_IDLE) || completing;

endmodule

`default_nettype wire

/* dcache_direct.sv */
`default_nettype none

`include "dmem_cfg.svh"

module dcache_direct (
  input  logic                 clk,
  input  logic                 rst_n,

  // Read channel from the bridge
  input  logic                 cache_rd_valid,
  input  dmem_pkg::dmem_addr_t cache_rd_addr,
  output dmem_pkg::dmem_data_t cache_rd_data,
  output logic                 cache_rd_data_valid,

  // Write channel from the bridge
  input  logic                 cache_wr_valid,
  input  dmem_pkg::dmem_addr_t cache_wr_addr,
  input  dmem_pkg::dmem_data_t cache_wr_data,
  input  dmem_pkg::dmem_strb_t cache_wr_strb,
  output logic                 cache_wr_ready,

  // Main memory port
  output logic                 mem_req,
  output logic                 mem_we,
  output dmem_pkg::dmem_addr_t mem_addr,
  output dmem_pkg::dmem_data_t mem_wdata,
  output dmem_pkg::dmem_strb_t mem_wstrb,
  input  logic                 mem_ack,
  input  dmem_pkg::dmem_data_t mem_rdata
);

  localparam int unsigned IDX_W = dmem_pkg::DCACHE_IDX_W;

  typedef enum logic [1:0] {
    DC_IDLE,
    DC_HIT,
    DC_FILL,
    DC_WRITE
  } dcache_state_t;

  dcache_state_t state;

  // Line storage
  dmem_pkg::dmem_data_t         data_arr [`DMEM_CACHE_LINES];
  dmem_pkg::dcache_tag_t        tag_arr  [`DMEM_CACHE_LINES];
  logic [`DMEM_CACHE_LINES-1:0] valid_q;

  // Address split, index sits just above the byte offset
  dmem_pkg::dcache_idx_t rd_idx;
  dmem_pkg::dcache_tag_t rd_tag;
  dmem_pkg::dcache_idx_t wr_idx;
  dmem_pkg::dcache_tag_t wr_tag;
  dmem_pkg::dcache_idx_t fill_idx;
  dmem_pkg::dcache_tag_t fill_tag;

  logic                 rd_hit;
  logic                 wr_hit;
  dmem_pkg::dmem_data_t wr_merged;
  dmem_pkg::dmem_data_t rd_data_q;

  assign rd_idx   = cache_rd_addr[2 +: IDX_W];
  assign rd_tag   = cache_rd_addr[30:2+IDX_W];
  assign wr_idx   = cache_wr_addr[2 +: IDX_W];
  assign wr_tag   = cache_wr_addr[30:2+IDX_W];
  // The fill target is the read address parked on the memory port
  assign fill_idx = mem_addr[2 +: IDX_W];
  assign fill_tag = mem_addr[30:2+IDX_W];

  assign rd_hit = valid_q[rd_idx] && (tag_arr[rd_idx] == rd_tag);
  assign wr_hit = valid_q[wr_idx] && (tag_arr[wr_idx] == wr_tag);

  // Byte merge of the write into the cached word
  always_comb begin
    wr_merged = data_arr[wr_idx];
    for (int b = 0; b < 4; b++) begin
      if (cache_wr_strb[b]) begin
        wr_merged[8*b +: 8] = cache_wr_data[8*b +: 8];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state   <= DC_IDLE;
      mem_req <= 1'b0;
      valid_q <= '0;
    end else begin
      case (state)
        DC_IDLE: begin
          if (cache_rd_valid) begin
            if (rd_hit) begin
              state <= DC_HIT;
            end else begin
              state   <= DC_FILL;
              mem_req <= 1'b1;
            end
          end else if (cache_wr_valid) begin
            // Write-through, every write goes out to memory
            state   <= DC_WRITE;
            mem_req <= 1'b1;
          end
        end
        DC_HIT: begin
          state <= DC_IDLE;
        end
        DC_FILL: begin
          if (mem_ack) begin
            state             <= DC_IDLE;
            mem_req           <= 1'b0;
            valid_q[fill_idx] <= 1'b1;
          end
        end
        DC_WRITE: begin
          if (mem_ack) begin
            state   <= DC_IDLE;
            mem_req <= 1'b0;
          end
        end
        default: begin
          state <= DC_IDLE;
        end
      endcase
    end
  end

  // Arrays and memory request payload
  always_ff @(posedge clk) begin
    if (state == DC_IDLE) begin
      if (cache_rd_valid) begin
        rd_data_q <= data_arr[rd_idx];
        mem_we    <= 1'b0;
        mem_addr  <= cache_rd_addr;
        mem_wstrb <= '0;
      end else if (cache_wr_valid) begin
        mem_we    <= 1'b1;
        mem_addr  <= cache_wr_addr;
        mem_wdata <= cache_wr_data;
        mem_wstrb <= cache_wr_strb;
        // Update on hit only, no allocate on a write miss
        if (wr_hit) begin
          data_arr[wr_idx] <= wr_merged;
        end
      end
    end
    if ((state == DC_FILL) && mem_ack) begin
      data_arr[fill_idx] <= mem_rdata;
      tag_arr[fill_idx]  <= fill_tag;
    end
  end

  // Miss data forwarded straight from memory in the ack cycle
  assign cache_rd_data       = (state == DC_FILL) ? mem_rdata : rd_data_q;
  assign cache_rd_data_valid = (state == DC_HIT) || ((state == DC_FILL) && mem_ack);
  assign cache_wr_ready      = (state == DC_WRITE) && mem_ack;

endmodule

`default_nettype wire

/* main_mem.sv */
`default_nettype none

`include "dmem_cfg.svh"

module main_mem (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 mem_req,
  input  logic                 mem_we,
  input  dmem_pkg::dmem_addr_t mem_addr,
  input  dmem_pkg::dmem_data_t mem_wdata,
  input  dmem_pkg::dmem_strb_t mem_wstrb,
  output logic                 mem_ack,
  output dmem_pkg::dmem_data_t mem_rdata
);

  localparam int unsigned IDX_W = $clog2(`DMEM_MEM_WORDS);
  // Wide enough for a zero latency too
  localparam int unsigned CNT_W = $clog2(`DMEM_MEM_LATENCY + 2);

  dmem_pkg::dmem_data_t mem_q [`DMEM_MEM_WORDS];
  logic [IDX_W-1:0]     word_idx;
  logic                 busy_q;
  logic [CNT_W-1:0]     cnt_q;

  // Memory starts out cleared
  initial begin
    for (int i = 0; i < `DMEM_MEM_WORDS; i++) begin
      mem_q[i] = '0;
    end
  end

  assign word_idx = mem_addr[2 +: IDX_W];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy_q <= 1'b0;
      cnt_q  <= '0;
    end else if (busy_q) begin
      if (cnt_q == '0) begin
        busy_q <= 1'b0;
      end else begin
        cnt_q <= cnt_q - 1'b1;
      end
    end else if (mem_req) begin
      // New request, count out the wait cycles
      busy_q <= 1'b1;
      cnt_q  <= CNT_W'(`DMEM_MEM_LATENCY);
    end
  end

  // Access happens on the ack edge
  always_ff @(posedge clk) begin
    if (mem_ack && mem_we) begin
      for (int b = 0; b < 4; b++) begin
        if (mem_wstrb[b]) begin
          mem_q[word_idx][8*b +: 8] <= mem_wdata[8*b +: 8];
        end
      end
    end
  end

  assign mem_ack   = busy_q && (cnt_q == '0);
  assign mem_rdata = mem_q[word_idx];

endmodule

`default_nettype wire

/* io_bram.sv */
`default_nettype none

`include "dmem_cfg.svh"

module io_bram (
  input  logic                 clk,
  input  logic                 io_ren,
  input  dmem_pkg::dmem_addr_t io_raddr,
  input  logic                 io_wen,
  input  dmem_pkg::dmem_addr_t io_waddr,
  input  dmem_pkg::dmem_data_t io_wdata,
  input  dmem_pkg::dmem_strb_t io_wstrb,
  output dmem_pkg::dmem_data_t io_rdata
);

  localparam int unsigned IDX_W = $clog2(`DMEM_IO_WORDS);

  dmem_pkg::dmem_data_t ram_q [`DMEM_IO_WORDS];
  logic [IDX_W-1:0]     ridx;
  logic [IDX_W-1:0]     widx;

  initial begin
    for (int i = 0; i < `DMEM_IO_WORDS; i++) begin
      ram_q[i] = '0;
    end
  end

  // Word address wraps at the BRAM depth
  assign ridx = io_raddr[2 +: IDX_W];
  assign widx = io_waddr[2 +: IDX_W];

  always_ff @(posedge clk) begin
    for (int b = 0; b < 4; b++) begin
      if (io_wen && io_wstrb[b]) begin
        ram_q[widx][8*b +: 8] <= io_wdata[8*b +: 8];
      end
    end
    // Registered read, data one cycle after io_ren
    if (io_ren) begin
      io_rdata <= ram_q[ridx];
    end
  end

endmodule

`default_nettype wire

/* dmem_pkg.sv */
`default_nettype none

`include "dmem_cfg.svh"

package dmem_pkg;

  // Byte address, bit 31 selects the I/O region
  typedef logic [31:0] dmem_addr_t;
  typedef logic [31:0] dmem_data_t;
  typedef logic [3:0] dmem_strb_t;

  // Cache index width follows the line count
  localparam int unsigned DCACHE_IDX_W = $clog2(`DMEM_CACHE_LINES);

  typedef logic [DCACHE_IDX_W-1:0] dcache_idx_t;
  // Word-address bits 30 down to 2 + index width
  typedef logic [28-DCACHE_IDX_W:0] dcache_tag_t;

endpackage

`default_nettype wire

/* dmem_cfg.svh */
`ifndef DMEM_CFG_SVH
`define DMEM_CFG_SVH

// Data cache geometry
// One 32-bit word per line, must be a power of two
`define DMEM_CACHE_LINES 16

// Main memory depth in 32-bit words
// Power of two, addressed by the word-address bits above the byte offset
`define DMEM_MEM_WORDS 1024

// I/O BRAM depth in 32-bit words
// Address wraps modulo this depth
`define DMEM_IO_WORDS 64

// Wait cycles inserted by main memory for every access
// mem_ack follows mem_req by this value plus one
`define DMEM_MEM_LATENCY 4

`endif
